// ==== src.f ====
rtl/chip_ctrl_pkg.sv
rtl/tag_master.sv
rtl/tag_client.sv
rtl/dmc_cfg_bank.sv
rtl/dmc_param_assembler.sv
rtl/chip_ctrl_top.sv
tests/chip_ctrl_tb.sv

// ==== tests/chip_ctrl_tb.sv ====
`timescale 1ns/1ps

module chip_ctrl_tb;

  import chip_ctrl_pkg::*;

  localparam int max_rows       = 32;
  localparam int timeout_cycles = 100;

  logic                      clk;
  logic                      arst_n;
  logic                      tag_data;
  logic                      tag_en;
  logic                      core_reset;
  logic [core_did_width-1:0] core_did;
  logic                      core_cfg_new;
  dmc_timing_t               dmc_timing;
  logic                      dmc_sys_reset;
  logic                      cfg_ready;

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  tag_id_t                   row_id         [max_rows];
  logic                      row_dnr        [max_rows];
  int                        row_len        [max_rows];
  tag_payload_t              row_payload    [max_rows];
  // a set bit pauses the enable for one cycle before that packet bit
  logic [31:0]               row_gap        [max_rows];
  logic                      row_chain      [max_rows];
  logic                      exp_core_reset [max_rows];
  logic [core_did_width-1:0] exp_did        [max_rows];
  dmc_timing_t               exp_timing     [max_rows];
  logic                      exp_sys_reset  [max_rows];
  logic                      exp_ready      [max_rows];
  int                        exp_new        [max_rows];
  int                        n_rows;

  // reference state of the clients
  dmc_cfg_byte_t             model_bytes    [dmc_cfg_bytes];
  logic [dmc_cfg_bytes-1:0]  model_written;
  core_tag_payload_t         model_core;
  logic [31:0]               lcg_state;

  int                        checks;
  int                        errors;
  int                        row_errors;
  logic                      timed_out;
  string                     diff_name;
  logic [15:0]               diff_exp;
  logic [15:0]               diff_got;

  chip_ctrl_top i_chip_ctrl_top (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .tag_data_i     (tag_data),
    .tag_en_i       (tag_en),
    .core_reset_o   (core_reset),
    .core_did_o     (core_did),
    .core_cfg_new_o (core_cfg_new),
    .dmc_timing_o   (dmc_timing),
    .dmc_sys_reset_o(dmc_sys_reset),
    .cfg_ready_o    (cfg_ready)
  );

  always #20 clk = ~clk;

  function automatic tag_payload_t next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:8];
  endfunction

  // byte map of the timing record with the msb field first
  function automatic dmc_timing_t model_timing();
    dmc_timing_t t;
    t = {model_bytes[1], model_bytes[0],
         model_bytes[2][3:0], model_bytes[2][7:4],
         model_bytes[3][3:0], model_bytes[3][7:4],
         model_bytes[4][3:0], model_bytes[4][7:4],
         model_bytes[5][3:0], model_bytes[5][7:4],
         model_bytes[6][3:0], model_bytes[6][7:4],
         model_bytes[7][3:0], model_bytes[7][6:4],
         model_bytes[8][3:0], model_bytes[8][7:4],
         model_bytes[9][1:0], model_bytes[9][7:2],
         model_bytes[11], model_bytes[10]};
    return t;
  endfunction

  task automatic add_row(input int id, input logic dnr, input int len,
                         input tag_payload_t payload, input logic [31:0] gap,
                         input logic chain);
    tag_payload_t eff;
    eff = payload;
    if (len < tag_max_payload) begin
      eff = payload & ((tag_payload_t'(1) << len) - 1'b1);
    end
    if (!dnr) begin
      eff = '0;
    end
    if (id == core_client_id) begin
      model_core = eff[$bits(core_tag_payload_t)-1:0];
    end else if (id >= dmc_cfg_base_id && id < dmc_cfg_base_id + dmc_cfg_bytes) begin
      model_bytes[id-dmc_cfg_base_id]   = eff[7:0];
      model_written[id-dmc_cfg_base_id] = 1'b1;
    end
    row_id[n_rows]         = tag_id_t'(id);
    row_dnr[n_rows]        = dnr;
    row_len[n_rows]        = len;
    row_payload[n_rows]    = payload;
    row_gap[n_rows]        = gap;
    row_chain[n_rows]      = chain;
    exp_core_reset[n_rows] = model_core.reset;
    exp_did[n_rows]        = model_core.did;
    exp_timing[n_rows]     = model_timing();
    exp_sys_reset[n_rows]  = model_bytes[12][0];
    exp_ready[n_rows]      = (&model_written) && !model_core.reset;
    exp_new[n_rows]        = (id == core_client_id) ? 1 : 0;
    n_rows++;
  endtask

  task automatic build_table();
    logic [31:0] gap;
    lcg_state     = 32'd61;
    n_rows        = 0;
    model_written = '0;
    model_core    = '0;
    for (int k = 0; k < dmc_cfg_bytes; k++) begin
      model_bytes[k] = '0;
    end
    // core held in reset with did 0x0b
    add_row(core_client_id, 1'b1, 6, 16'h002b, 32'h0, 1'b0);
    for (int k = 0; k < dmc_cfg_bytes; k++) begin
      gap = 32'h0;
      if (k == 3) gap = 32'h1 << 3;
      if (k == 7) gap = 32'h1 << 14;
      add_row(dmc_cfg_base_id + k, 1'b1, 8, next_random(), gap, k == 5);
    end
    // releasing the core lets ready rise
    add_row(core_client_id, 1'b1, 6, 16'h0013, 32'h0, 1'b0);
    add_row(dmc_cfg_base_id + 4, 1'b0, 8, 16'h00a5, 32'h0, 1'b0);
    add_row(14, 1'b1, 16, 16'hffff, 32'h0, 1'b0);
    add_row(63, 1'b1, 16, next_random(), 32'h0000_0c12, 1'b0);
    add_row(dmc_cfg_base_id + 2, 1'b1, 3, 16'hfffd, 32'h0, 1'b0);
    add_row(dmc_cfg_base_id + 8, 1'b1, 16, next_random(), 32'h0, 1'b1);
    add_row(dmc_cfg_base_id + 12, 1'b1, 1, 16'h0001, 32'h0, 1'b0);
    add_row(dmc_cfg_base_id + 9, 1'b1, 8, next_random(), 32'h000a_8000, 1'b0);
    add_row(core_client_id, 1'b0, 6, 16'h003f, 32'h0, 1'b0);
    add_row(core_client_id, 1'b1, 6, 16'h0021, 32'h0000_0100, 1'b0);
  endtask

  //////////////////////////////
  // stream driver
  //////////////////////////////

  task automatic send_packet(input int r);
    logic [27:0] bits;
    tag_len_t    len_field;
    int          nbits;
    bits      = '0;
    len_field = tag_len_t'(row_len[r] - 1);
    bits[0]   = 1'b1;
    for (int i = 0; i < tag_id_width; i++) bits[1+i] = row_id[r][i];
    bits[7] = row_dnr[r];
    for (int i = 0; i < tag_len_width; i++) bits[8+i] = len_field[i];
    for (int i = 0; i < row_len[r]; i++) bits[12+i] = row_payload[r][i];
    nbits = 12 + row_len[r];
    for (int i = 0; i < nbits; i++) begin
      if (row_gap[r][i]) begin
        // junk on the data line while paused
        @(posedge clk);
        #2;
        tag_en   = 1'b0;
        tag_data = 1'b1;
      end
      @(posedge clk);
      #2;
      tag_en   = 1'b1;
      tag_data = bits[i];
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #2;
    tag_en   = 1'b1;
    tag_data = 1'b0;
  endtask

  task automatic wait_strobe(output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < timeout_cycles) begin
      @(negedge clk);
      if (i_chip_ctrl_top.tag_v) seen = 1'b1;
      n++;
    end
  endtask

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_bit(input string name, input logic e, input logic g);
    checks++;
    if (g !== e) begin
      errors++;
      row_errors++;
      $display("[FAIL] %0t %s exp %0b got %0b", $time, name, e, g);
    end
  endtask

  task automatic check_did(input string name, input logic [core_did_width-1:0] e,
                           input logic [core_did_width-1:0] g);
    checks++;
    if (g !== e) begin
      errors++;
      row_errors++;
      $display("[FAIL] %0t %s exp %0h got %0h", $time, name, e, g);
    end
  endtask

  task automatic check_count(input string name, input int e, input int g);
    checks++;
    if (g != e) begin
      errors++;
      row_errors++;
      $display("[FAIL] %0t %s exp %0d got %0d", $time, name, e, g);
    end
  endtask

  task automatic note_field_diff(input string name, input logic [15:0] e,
                                 input logic [15:0] g);
    if (diff_name == "" && g !== e) begin
      diff_name = name;
      diff_exp  = e;
      diff_got  = g;
    end
  endtask

  task automatic check_timing(input string name, input dmc_timing_t e, input dmc_timing_t g);
    diff_name = "";
    note_field_diff("trefi", e.trefi, g.trefi);
    note_field_diff("tmrd", e.tmrd, g.tmrd);
    note_field_diff("trfc", e.trfc, g.trfc);
    note_field_diff("trc", e.trc, g.trc);
    note_field_diff("trp", e.trp, g.trp);
    note_field_diff("tras", e.tras, g.tras);
    note_field_diff("trrd", e.trrd, g.trrd);
    note_field_diff("trcd", e.trcd, g.trcd);
    note_field_diff("twr", e.twr, g.twr);
    note_field_diff("twtr", e.twtr, g.twtr);
    note_field_diff("trtp", e.trtp, g.trtp);
    note_field_diff("tcas", e.tcas, g.tcas);
    note_field_diff("dqs_sel_cal", e.dqs_sel_cal, g.dqs_sel_cal);
    note_field_diff("col_width", e.col_width, g.col_width);
    note_field_diff("row_width", e.row_width, g.row_width);
    note_field_diff("bank_width", e.bank_width, g.bank_width);
    note_field_diff("bank_pos", e.bank_pos, g.bank_pos);
    note_field_diff("init_cycles", e.init_cycles, g.init_cycles);
    checks++;
    if (diff_name != "") begin
      errors++;
      row_errors++;
      $display("[FAIL] %0t %s.%s exp %0h got %0h", $time, name, diff_name, diff_exp, diff_got);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    logic seen;
    int   new_cnt;
    clk       = 1'b0;
    arst_n    = 1'b0;
    tag_data  = 1'b0;
    tag_en    = 1'b0;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    row_errors = 0;
    check_bit("core_reset_o", 1'b0, core_reset);
    check_bit("core_cfg_new_o", 1'b0, core_cfg_new);
    check_bit("cfg_ready_o", 1'b0, cfg_ready);
    check_bit("dmc_sys_reset_o", 1'b0, dmc_sys_reset);
    check_timing("dmc_timing_o", '0, dmc_timing);
    $display("after reset %s", (row_errors == 0) ? "pass" : "mismatch");
    for (int r = 0; r < n_rows && !timed_out; r++) begin
      row_errors = 0;
      send_packet(r);
      if (row_chain[r]) begin
        $display("row %0d id %0d sent back to back with the next row", r, row_id[r]);
      end else begin
        drive_idle();
        wait_strobe(seen);
        if (!seen) begin
          timed_out = 1'b1;
          $display("row %0d gave no tag strobe within %0d cycles", r, timeout_cycles);
        end else begin
          new_cnt = 0;
          repeat (4) begin
            @(negedge clk);
            if (core_cfg_new) new_cnt++;
          end
          check_bit("core_reset_o", exp_core_reset[r], core_reset);
          check_did("core_did_o", exp_did[r], core_did);
          check_count("core_cfg_new_o pulses", exp_new[r], new_cnt);
          check_timing("dmc_timing_o", exp_timing[r], dmc_timing);
          check_bit("dmc_sys_reset_o", exp_sys_reset[r], dmc_sys_reset);
          check_bit("cfg_ready_o", exp_ready[r], cfg_ready);
          $display("row %0d id %0d %s", r, row_id[r], (row_errors == 0) ? "pass" : "mismatch");
        end
      end
    end
    $display("rows %0d checks %0d errors %0d", n_rows, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== rtl/chip_ctrl_top.sv ====
`timescale 1ns/1ps

module chip_ctrl_top (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      tag_data_i,
  input  logic                                      tag_en_i,
  output logic                                      core_reset_o,
  output logic [chip_ctrl_pkg::core_did_width-1:0]  core_did_o,
  output logic                                      core_cfg_new_o,
  output chip_ctrl_pkg::dmc_timing_t                dmc_timing_o,
  output logic                                      dmc_sys_reset_o,
  output logic                                      cfg_ready_o
);

  import chip_ctrl_pkg::*;

  // broadcast from the master
  logic                              tag_v;
  tag_id_t                           tag_id;
  logic                              tag_data_not_reset;
  tag_payload_t                      tag_payload;

  core_tag_payload_t                 core_data;
  dmc_cfg_byte_t [dmc_cfg_bytes-1:0] cfg_bytes;
  logic [dmc_cfg_bytes-1:0]          cfg_written;

  //////////////////////////////
  // tag network
  //////////////////////////////

  tag_master i_tag_master (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .tag_data_i          (tag_data_i),
    .tag_en_i            (tag_en_i),
    .tag_v_o             (tag_v),
    .tag_id_o            (tag_id),
    .tag_data_not_reset_o(tag_data_not_reset),
    .tag_payload_o       (tag_payload)
  );

  tag_client #(
    .client_id_p(core_client_id),
    .payload_t  (core_tag_payload_t)
  ) i_core_client (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .tag_v_i             (tag_v),
    .tag_id_i            (tag_id),
    .tag_data_not_reset_i(tag_data_not_reset),
    .tag_payload_i       (tag_payload),
    .data_r_o            (core_data),
    .new_r_o             (core_cfg_new_o)
  );

  assign core_reset_o = core_data.reset;
  assign core_did_o   = core_data.did;

  //////////////////////////////
  // dram controller config
  //////////////////////////////

  dmc_cfg_bank i_dmc_cfg_bank (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .tag_v_i             (tag_v),
    .tag_id_i            (tag_id),
    .tag_data_not_reset_i(tag_data_not_reset),
    .tag_payload_i       (tag_payload),
    .cfg_bytes_o         (cfg_bytes),
    .written_o           (cfg_written)
  );

  dmc_param_assembler i_dmc_param_assembler (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cfg_bytes_i    (cfg_bytes),
    .written_i      (cfg_written),
    .core_reset_i   (core_data.reset),
    .dmc_timing_o   (dmc_timing_o),
    .dmc_sys_reset_o(dmc_sys_reset_o),
    .cfg_ready_o    (cfg_ready_o)
  );

endmodule

// ==== rtl/dmc_param_assembler.sv ====
`timescale 1ns/1ps

module dmc_param_assembler (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n_i,
  input  chip_ctrl_pkg::dmc_cfg_byte_t [chip_ctrl_pkg::dmc_cfg_bytes-1:0] cfg_bytes_i,
  input  logic [chip_ctrl_pkg::dmc_cfg_bytes-1:0]                   written_i,
  input  logic                                                      core_reset_i,
  output chip_ctrl_pkg::dmc_timing_t                                dmc_timing_o,
  output logic                                                      dmc_sys_reset_o,
  output logic                                                      cfg_ready_o
);

  import chip_ctrl_pkg::*;

  dmc_timing_t timing_n;
  logic        sys_reset_n;
  logic        ready_n;

  //////////////////////////////
  // byte to field map
  //////////////////////////////

  always_comb begin
    timing_n.trefi       = {cfg_bytes_i[1], cfg_bytes_i[0]};
    timing_n.tmrd        = cfg_bytes_i[2][3:0];
    timing_n.trfc        = cfg_bytes_i[2][7:4];
    timing_n.trc         = cfg_bytes_i[3][3:0];
    timing_n.trp         = cfg_bytes_i[3][7:4];
    timing_n.tras        = cfg_bytes_i[4][3:0];
    timing_n.trrd        = cfg_bytes_i[4][7:4];
    timing_n.trcd        = cfg_bytes_i[5][3:0];
    timing_n.twr         = cfg_bytes_i[5][7:4];
    timing_n.twtr        = cfg_bytes_i[6][3:0];
    timing_n.trtp        = cfg_bytes_i[6][7:4];
    timing_n.tcas        = cfg_bytes_i[7][3:0];
    // bit 7 of byte 7 is spare
    timing_n.dqs_sel_cal = cfg_bytes_i[7][6:4];
    timing_n.col_width   = cfg_bytes_i[8][3:0];
    timing_n.row_width   = cfg_bytes_i[8][7:4];
    timing_n.bank_width  = cfg_bytes_i[9][1:0];
    timing_n.bank_pos    = cfg_bytes_i[9][7:2];
    timing_n.init_cycles = {cfg_bytes_i[11], cfg_bytes_i[10]};
  end

  assign sys_reset_n = cfg_bytes_i[12][0];

  // every byte seen and the core out of reset
  assign ready_n = (&written_i) && !core_reset_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dmc_timing_o    <= '0;
      dmc_sys_reset_o <= 1'b0;
      cfg_ready_o     <= 1'b0;
    end else begin
      dmc_timing_o    <= timing_n;
      dmc_sys_reset_o <= sys_reset_n;
      cfg_ready_o     <= ready_n;
    end
  end

endmodule

// ==== rtl/dmc_cfg_bank.sv ====
`timescale 1ns/1ps

module dmc_cfg_bank (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n_i,
  input  logic                                                      tag_v_i,
  input  chip_ctrl_pkg::tag_id_t                                    tag_id_i,
  input  logic                                                      tag_data_not_reset_i,
  input  chip_ctrl_pkg::tag_payload_t                               tag_payload_i,
  output chip_ctrl_pkg::dmc_cfg_byte_t [chip_ctrl_pkg::dmc_cfg_bytes-1:0] cfg_bytes_o,
  output logic [chip_ctrl_pkg::dmc_cfg_bytes-1:0]                   written_o
);

  import chip_ctrl_pkg::*;

  logic [dmc_cfg_bytes-1:0] new_w;
  logic [dmc_cfg_bytes-1:0] written_r;

  //////////////////////////////
  // one client per byte
  //////////////////////////////

  for (genvar k = 0; k < dmc_cfg_bytes; k++) begin : g_byte
    tag_client #(
      .client_id_p(dmc_cfg_base_id + k),
      .payload_t  (dmc_cfg_byte_t)
    ) i_tag_client (
      .clk_i               (clk_i),
      .arst_n_i            (arst_n_i),
      .tag_v_i             (tag_v_i),
      .tag_id_i            (tag_id_i),
      .tag_data_not_reset_i(tag_data_not_reset_i),
      .tag_payload_i       (tag_payload_i),
      .data_r_o            (cfg_bytes_o[k]),
      .new_r_o             (new_w[k])
    );
  end

  // reset packets also set the sticky mask
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      written_r <= '0;
    end else begin
      written_r <= written_r | new_w;
    end
  end

  assign written_o = written_r;

endmodule

// ==== rtl/tag_client.sv ====
`timescale 1ns/1ps

module tag_client #(
  parameter int  client_id_p = 0,
  parameter type payload_t   = chip_ctrl_pkg::dmc_cfg_byte_t
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        tag_v_i,
  input  chip_ctrl_pkg::tag_id_t      tag_id_i,
  input  logic                        tag_data_not_reset_i,
  input  chip_ctrl_pkg::tag_payload_t tag_payload_i,
  output payload_t                    data_r_o,
  output logic                        new_r_o
);

  import chip_ctrl_pkg::*;

  localparam int width_lp = $bits(payload_t);

  logic     hit;
  payload_t load_val;

  assign hit = tag_v_i && (tag_id_i == tag_id_t'(client_id_p));

  // reset packets load the all zero default
  assign load_val = tag_data_not_reset_i ? payload_t'(tag_payload_i[width_lp-1:0]) : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_r_o <= '0;
      new_r_o  <= 1'b0;
    end else begin
      new_r_o <= hit;
      if (hit) begin
        data_r_o <= load_val;
      end
    end
  end

endmodule

// ==== rtl/tag_master.sv ====
`timescale 1ns/1ps

module tag_master (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        tag_data_i,
  input  logic                        tag_en_i,
  output logic                        tag_v_o,
  output chip_ctrl_pkg::tag_id_t      tag_id_o,
  output logic                        tag_data_not_reset_o,
  output chip_ctrl_pkg::tag_payload_t tag_payload_o
);

  import chip_ctrl_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_id,
    st_flag,
    st_len,
    st_data
  } state_e;

  state_e       state_r;
  tag_cnt_t     cnt_r;
  logic         tag_v_r;

  // header and payload being assembled
  tag_id_t      id_r;
  logic         data_not_reset_r;
  tag_len_t     len_r;
  tag_payload_t payload_r;
  tag_payload_t payload_n;

  // fields of the last complete packet
  tag_id_t      tag_id_r;
  logic         tag_data_not_reset_r;
  tag_payload_t tag_payload_r;

  logic         last_id;
  logic         last_len;
  logic         last_data;

  assign last_id   = (cnt_r == tag_cnt_t'(tag_id_width - 1));
  assign last_len  = (cnt_r == tag_cnt_t'(tag_len_width - 1));
  assign last_data = (cnt_r == tag_cnt_t'(len_r));

  // payload with the bit sampled this cycle folded in
  always_comb begin
    payload_n = payload_r;
    payload_n[cnt_r] = tag_data_i;
  end

  //////////////////////////////
  // packet fsm
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= st_idle;
      cnt_r   <= '0;
      tag_v_r <= 1'b0;
    end else begin
      tag_v_r <= 1'b0;
      // a low enable holds every field where it is
      if (tag_en_i) begin
        case (state_r)
          st_idle: begin
            // zeros between packets are ignored
            if (tag_data_i) begin
              state_r <= st_id;
              cnt_r   <= '0;
            end
          end
          st_id: begin
            if (last_id) begin
              state_r <= st_flag;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
          st_flag: begin
            state_r <= st_len;
          end
          st_len: begin
            if (last_len) begin
              state_r <= st_data;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
          st_data: begin
            if (last_data) begin
              state_r <= st_idle;
              tag_v_r <= 1'b1;
            end else begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
          default: begin
            state_r <= st_idle;
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // field shifters
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (tag_en_i) begin
      case (state_r)
        st_idle: begin
          payload_r <= '0;
        end
        st_id: begin
          id_r <= {tag_data_i, id_r[tag_id_width-1:1]};
        end
        st_flag: begin
          data_not_reset_r <= tag_data_i;
        end
        st_len: begin
          len_r <= {tag_data_i, len_r[tag_len_width-1:1]};
        end
        st_data: begin
          payload_r <= payload_n;
          if (last_data) begin
            tag_id_r             <= id_r;
            tag_data_not_reset_r <= data_not_reset_r;
            tag_payload_r        <= payload_n;
          end
        end
        default: begin
          payload_r <= '0;
        end
      endcase
    end
  end

  assign tag_v_o              = tag_v_r;
  assign tag_id_o             = tag_id_r;
  assign tag_data_not_reset_o = tag_data_not_reset_r;
  assign tag_payload_o        = tag_payload_r;

endmodule

// ==== rtl/chip_ctrl_pkg.sv ====
package chip_ctrl_pkg;

  //////////////////////////////
  // tag stream format
  //////////////////////////////

  // client id field sent lsb first
  localparam int tag_id_width = 6;

  // length field holds payload length minus one
  localparam int tag_len_width = 4;

  // widest payload carried by one packet
  localparam int tag_max_payload = 16;

  // one bit counter serves the id, length and payload fields
  localparam int tag_cnt_width = $clog2(tag_max_payload);

  typedef logic [tag_id_width-1:0]    tag_id_t;
  typedef logic [tag_len_width-1:0]   tag_len_t;
  typedef logic [tag_max_payload-1:0] tag_payload_t;
  typedef logic [tag_cnt_width-1:0]   tag_cnt_t;

  //////////////////////////////
  // core control client
  //////////////////////////////

  localparam int core_did_width = 5;
  localparam int core_client_id = 0;

  // reset sits above did
  typedef struct packed {
    logic                      reset;
    logic [core_did_width-1:0] did;
  } core_tag_payload_t;

  //////////////////////////////
  // dram controller config
  //////////////////////////////

  localparam int dmc_cfg_bytes = 13;

  // byte k answers to client dmc_cfg_base_id + k
  localparam int dmc_cfg_base_id = 1;

  typedef logic [7:0] dmc_cfg_byte_t;

  typedef struct packed {
    logic [15:0] trefi;
    logic [3:0]  tmrd;
    logic [3:0]  trfc;
    logic [3:0]  trc;
    logic [3:0]  trp;
    logic [3:0]  tras;
    logic [3:0]  trrd;
    logic [3:0]  trcd;
    logic [3:0]  twr;
    logic [3:0]  twtr;
    logic [3:0]  trtp;
    logic [3:0]  tcas;
    logic [2:0]  dqs_sel_cal;
    logic [3:0]  col_width;
    logic [3:0]  row_width;
    logic [1:0]  bank_width;
    logic [5:0]  bank_pos;
    logic [15:0] init_cycles;
  } dmc_timing_t;

endpackage
